// File: Bender.yml
package:
  name: inst_decode

sources:
  - include_dirs:
      - include
    files:
      - source/id_pkg.sv
      - source/decoder.sv
      - source/regfile.sv
      - source/regs_forward.sv
      - source/resolve_delayslot.sv
      - source/inst_decode.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_inst_decode.sv

// File: include/id_cfg.svh
// register count, data width and register index width for the decode stage
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// architectural register count
`define ID_N_REG 32

// data word width
`define ID_DATA_W 32

// register index width, log2 of the register count
`define ID_REG_ADDR_W 5

`endif

// File: sim.f
+incdir+include
source/id_pkg.sv
source/decoder.sv
source/regfile.sv
source/regs_forward.sv
source/resolve_delayslot.sv
source/inst_decode.sv
verif/tb_inst_decode.sv

// File: source/decoder.sv
// decoder: opcode and funct decode into the decoder response struct
module decoder (
    input  id_pkg::uint32_t       inst_i,
    output id_pkg::decoder_resp_t decoder_resp_o
);

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // funct field of SPECIAL
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // link register for JAL
    localparam id_pkg::reg_addr_t REG_RA = 5'd31;

    logic [5:0]      opcode;
    logic [5:0]      funct;
    id_pkg::uint32_t imm_sext;
    id_pkg::uint32_t imm_zext;
    id_pkg::uint32_t imm_upper;
    id_pkg::uint32_t imm_jump;

    assign opcode    = inst_i[31:26];
    assign funct     = inst_i[5:0];
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext  = {16'b0, inst_i[15:0]};
    assign imm_upper = {inst_i[15:0], 16'b0};
    // word index of the jump target
    assign imm_jump  = {6'b0, inst_i[25:0]};

    always_comb begin
        decoder_resp_o        = '0;
        decoder_resp_o.rs1    = inst_i[25:21];
        decoder_resp_o.rs2    = inst_i[20:16];
        decoder_resp_o.alu_op = id_pkg::NOP;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: decoder_resp_o.alu_op = id_pkg::ADD;
                    FN_SUBU: decoder_resp_o.alu_op = id_pkg::SUB;
                    FN_AND:  decoder_resp_o.alu_op = id_pkg::AND;
                    FN_OR:   decoder_resp_o.alu_op = id_pkg::OR;
                    FN_XOR:  decoder_resp_o.alu_op = id_pkg::XOR;
                    FN_SLT:  decoder_resp_o.alu_op = id_pkg::SLT;
                    default: decoder_resp_o.alu_op = id_pkg::NOP;
                endcase
                // unsupported funct stays a plain NOP
                if (decoder_resp_o.alu_op != id_pkg::NOP) begin
                    decoder_resp_o.rd     = inst_i[15:11];
                    decoder_resp_o.reg_we = 1'b1;
                end
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                decoder_resp_o.rd      = inst_i[20:16];
                decoder_resp_o.reg_we  = 1'b1;
                decoder_resp_o.use_imm = 1'b1;
                decoder_resp_o.imm     = imm_sext;
                decoder_resp_o.alu_op  = id_pkg::ADD;
                if (opcode == OP_ORI) begin
                    decoder_resp_o.imm    = imm_zext;
                    decoder_resp_o.alu_op = id_pkg::OR;
                end
                if (opcode == OP_LUI) begin
                    decoder_resp_o.imm    = imm_upper;
                    decoder_resp_o.alu_op = id_pkg::LUI;
                end
                if (opcode == OP_LW) begin
                    decoder_resp_o.is_load = 1'b1;
                    decoder_resp_o.be      = 4'b1111;
                end
            end
            OP_SW: begin
                decoder_resp_o.use_imm  = 1'b1;
                decoder_resp_o.imm      = imm_sext;
                decoder_resp_o.alu_op   = id_pkg::ADD;
                decoder_resp_o.is_store = 1'b1;
                decoder_resp_o.be       = 4'b1111;
            end
            OP_BEQ, OP_BNE: begin
                // compare in execute by subtraction
                decoder_resp_o.imm       = imm_sext;
                decoder_resp_o.alu_op    = id_pkg::SUB;
                decoder_resp_o.is_branch = 1'b1;
            end
            OP_J, OP_JAL: begin
                decoder_resp_o.imm     = imm_jump;
                decoder_resp_o.is_jump = 1'b1;
                if (opcode == OP_JAL) begin
                    decoder_resp_o.rd     = REG_RA;
                    decoder_resp_o.reg_we = 1'b1;
                end
            end
            default: begin
                decoder_resp_o.alu_op = id_pkg::NOP;
            end
        endcase
    end

endmodule

// File: source/id_pkg.sv
// id_pkg: width typedefs, ALU op and delay-slot enums, pipeline structs
`include "id_cfg.svh"

package id_pkg;

    typedef logic [`ID_DATA_W-1:0]     uint32_t;
    typedef logic [31:0]               virt_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]                byte_en_t;

    // operation handed to execute
    typedef enum logic [3:0] {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        LUI
    } alu_op_t;

    // delay-slot tracking
    typedef enum logic {
        IDLE,
        EXPECT_SLOT
    } ds_state_t;

    // write-back request from execute
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        uint32_t   wrdata;
    } regs_wreq_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        // already sign or zero extended
        uint32_t   imm;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      reg_we;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_jump;
        byte_en_t  be;
    } decoder_resp_t;

    typedef struct packed {
        virt_t    vaddr;
        uint32_t  wrdata;
        byte_en_t be;
        logic     read;
        logic     write;
    } dcache_req_t;

    // IF/ID register
    typedef struct packed {
        logic    valid;
        virt_t   vaddr;
        uint32_t inst;
    } pipe_if_t;

    // feedback from execute, sampled in the same cycle
    typedef struct packed {
        regs_wreq_t regs_wreq;
    } pipe_ex_t;

    // ID/EX register
    typedef struct packed {
        logic          valid;
        virt_t         vaddr;
        uint32_t       regs_rddata0;
        uint32_t       regs_rddata1;
        decoder_resp_t decode_resp;
        logic          delayslot;
        dcache_req_t   dcache_req;
    } pipe_id_t;

endpackage

// File: source/inst_decode.sv
// inst_decode: decode stage top with operand read, dcache request and ID/EX register
module inst_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             ready_i,
    output logic             ready_o,
    input  id_pkg::pipe_if_t pipe_if_i,
    input  logic             pipe_if_flush_i,
    input  id_pkg::pipe_ex_t pipe_ex_i,
    output id_pkg::pipe_id_t pipe_id_n_o,
    output id_pkg::pipe_id_t pipe_id_o
);

    id_pkg::decoder_resp_t decoder_resp;
    id_pkg::uint32_t       rf_rddata0;
    id_pkg::uint32_t       rf_rddata1;
    id_pkg::uint32_t       operand0;
    id_pkg::uint32_t       operand1;
    logic                  delayslot;
    id_pkg::dcache_req_t   dcache_req;

    // no buffering here, stall goes straight back to fetch
    assign ready_o = ready_i;

    decoder decoder_inst (
        .inst_i         (pipe_if_i.inst),
        .decoder_resp_o (decoder_resp)
    );

    regfile regfile_inst (
        .clk            (clk),
        .rst            (rst),
        .regs_wreq_i    (pipe_ex_i.regs_wreq),
        .regs_raddr0_i  (decoder_resp.rs1),
        .regs_raddr1_i  (decoder_resp.rs2),
        .regs_rddata0_o (rf_rddata0),
        .regs_rddata1_o (rf_rddata1)
    );

    regs_forward regs_forward_inst (
        .regs_raddr0_i  (decoder_resp.rs1),
        .regs_raddr1_i  (decoder_resp.rs2),
        .regs_rddata0_i (rf_rddata0),
        .regs_rddata1_i (rf_rddata1),
        .pipe_ex_i      (pipe_ex_i),
        .regs_rddata0_o (operand0),
        .regs_rddata1_o (operand1)
    );

    resolve_delayslot resolve_delayslot_inst (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (pipe_if_flush_i),
        .accept_i       (ready_i),
        .valid_i        (pipe_if_i.valid),
        .is_ctrl_xfer_i (decoder_resp.is_branch | decoder_resp.is_jump),
        .delayslot_o    (delayslot)
    );

    // base plus sign-extended offset, word access only
    assign dcache_req.vaddr  = operand0 + {{16{pipe_if_i.inst[15]}}, pipe_if_i.inst[15:0]};
    assign dcache_req.wrdata = operand1;
    assign dcache_req.be     = decoder_resp.be;
    assign dcache_req.read   = decoder_resp.is_load;
    assign dcache_req.write  = decoder_resp.is_store;

    assign pipe_id_n_o.valid        = pipe_if_i.valid;
    assign pipe_id_n_o.vaddr        = pipe_if_i.vaddr;
    assign pipe_id_n_o.regs_rddata0 = operand0;
    assign pipe_id_n_o.regs_rddata1 = operand1;
    assign pipe_id_n_o.decode_resp  = decoder_resp;
    assign pipe_id_n_o.delayslot    = delayslot;
    assign pipe_id_n_o.dcache_req   = dcache_req;

    // flush wins over stall and drops the whole entry
    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_id_o <= '0;
        end else if (pipe_if_flush_i) begin
            pipe_id_o <= '0;
        end else if (ready_i) begin
            pipe_id_o <= pipe_id_n_o;
        end
    end

endmodule

// File: source/regfile.sv
// regfile: 32-entry register file, one synchronous write port, two read ports
`include "id_cfg.svh"

module regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  id_pkg::regs_wreq_t    regs_wreq_i,
    input  id_pkg::reg_addr_t     regs_raddr0_i,
    input  id_pkg::reg_addr_t     regs_raddr1_i,
    output id_pkg::uint32_t       regs_rddata0_o,
    output id_pkg::uint32_t       regs_rddata1_o
);

    id_pkg::uint32_t regs [`ID_N_REG];

    // register zero never takes a write, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_N_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (regs_wreq_i.we && regs_wreq_i.waddr != '0) begin
            regs[regs_wreq_i.waddr] <= regs_wreq_i.wrdata;
        end
    end

    // new data shows up here one cycle after the write
    assign regs_rddata0_o = regs[regs_raddr0_i];
    assign regs_rddata1_o = regs[regs_raddr1_i];

endmodule

// File: source/regs_forward.sv
// regs_forward: bypass of execute write-back data onto both read operands
module regs_forward (
    input  id_pkg::reg_addr_t regs_raddr0_i,
    input  id_pkg::reg_addr_t regs_raddr1_i,
    input  id_pkg::uint32_t   regs_rddata0_i,
    input  id_pkg::uint32_t   regs_rddata1_i,
    input  id_pkg::pipe_ex_t  pipe_ex_i,
    output id_pkg::uint32_t   regs_rddata0_o,
    output id_pkg::uint32_t   regs_rddata1_o
);

    // pick write-back data when execute writes this register now
    function automatic id_pkg::uint32_t fwd_sel(
        input id_pkg::reg_addr_t  raddr,
        input id_pkg::uint32_t    rddata,
        input id_pkg::regs_wreq_t wreq
    );
        logic hit;
        hit = wreq.we && (wreq.waddr != '0) && (wreq.waddr == raddr);
        return hit ? wreq.wrdata : rddata;
    endfunction

    assign regs_rddata0_o = fwd_sel(regs_raddr0_i, regs_rddata0_i, pipe_ex_i.regs_wreq);
    assign regs_rddata1_o = fwd_sel(regs_raddr1_i, regs_rddata1_i, pipe_ex_i.regs_wreq);

endmodule

// File: source/resolve_delayslot.sv
// resolve_delayslot: FSM marking the instruction after a branch or jump
module resolve_delayslot (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    input  logic accept_i,
    input  logic valid_i,
    input  logic is_ctrl_xfer_i,
    output logic delayslot_o
);

    id_pkg::ds_state_t state_q;

    // bubbles and stalled cycles keep the state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= id_pkg::IDLE;
        end else if (flush_i) begin
            state_q <= id_pkg::IDLE;
        end else if (accept_i && valid_i) begin
            if (is_ctrl_xfer_i) begin
                state_q <= id_pkg::EXPECT_SLOT;
            end else begin
                state_q <= id_pkg::IDLE;
            end
        end
    end

    // current instruction sits in a delay slot
    assign delayslot_o = (state_q == id_pkg::EXPECT_SLOT);

endmodule

// File: verif/tb_inst_decode.sv
// tb_inst_decode: testbench with reference decode, register model, stimulus, compare and watchdog
`include "id_cfg.svh"

module tb_inst_decode;

    localparam int N_RESET   = 3;
    localparam int N_DECODE  = 40;
    localparam int N_REGFILE = 30;
    localparam int N_FORWARD = 20;
    localparam int N_MEM     = 20;
    localparam int N_CTRL    = 40;
    localparam int MARGIN    = 50;
    localparam int TOTAL     = N_RESET + N_DECODE + N_REGFILE + N_FORWARD + N_MEM + N_CTRL;

    logic             clk;
    logic             rst;
    logic             ready_i;
    logic             ready_o;
    logic             pipe_if_flush_i;
    id_pkg::pipe_if_t pipe_if_i;
    id_pkg::pipe_ex_t pipe_ex_i;
    id_pkg::pipe_id_t pipe_id_n_o;
    id_pkg::pipe_id_t pipe_id_o;

    // register model, delay-slot model and expected ID/EX contents
    id_pkg::uint32_t  shadow [`ID_N_REG];
    logic             ds_model;
    id_pkg::pipe_id_t exp_hold;
    id_pkg::pipe_id_t exp_q [$];
    id_pkg::pipe_id_t exp_next;
    logic             next_check_en;
    id_pkg::virt_t    pc;
    int               n_checks;
    int               n_errors;
    int               err_base;

    inst_decode UUT (
        .clk             (clk),
        .rst             (rst),
        .ready_i         (ready_i),
        .ready_o         (ready_o),
        .pipe_if_i       (pipe_if_i),
        .pipe_if_flush_i (pipe_if_flush_i),
        .pipe_ex_i       (pipe_ex_i),
        .pipe_id_n_o     (pipe_id_n_o),
        .pipe_id_o       (pipe_id_o)
    );

    always #5 clk = ~clk;

    function automatic id_pkg::uint32_t r_inst(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic id_pkg::uint32_t i_inst(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::regs_wreq_t wreq_of(input logic we, input logic [4:0] addr,
                                                   input id_pkg::uint32_t data);
        id_pkg::regs_wreq_t w;
        w.we     = we;
        w.waddr  = addr;
        w.wrdata = data;
        return w;
    endfunction

    // kinds 0..5 are ALU and unsupported encodings, 6..11 memory and control transfer
    function automatic id_pkg::uint32_t rand_inst(input int unsigned kind);
        id_pkg::uint32_t r;
        logic [5:0]      fn;
        r = $urandom;
        case ($urandom_range(0, 5))
            0: fn = 6'h21;
            1: fn = 6'h23;
            2: fn = 6'h24;
            3: fn = 6'h25;
            4: fn = 6'h26;
            default: fn = 6'h2a;
        endcase
        case (kind)
            0: r = r_inst(fn, r[25:21], r[20:16], r[15:11]);
            1: r[31:26] = 6'h09;
            2: r[31:26] = 6'h0d;
            3: r[31:26] = 6'h0f;
            4: r[31:26] = ($urandom_range(0, 1) != 0) ? 6'h08 : 6'h3f;
            5: r = r_inst(6'h00, r[25:21], r[20:16], r[15:11]);
            6: r[31:26] = 6'h23;
            7: r[31:26] = 6'h2b;
            8: r[31:26] = 6'h04;
            9: r[31:26] = 6'h05;
            10: r[31:26] = 6'h02;
            default: r[31:26] = 6'h03;
        endcase
        return r;
    endfunction

    // register read as seen in decode, with same-cycle bypass of the execute write
    function automatic id_pkg::uint32_t read_operand(input logic [4:0] addr,
                                                     input id_pkg::regs_wreq_t wreq);
        if (wreq.we && wreq.waddr != 5'd0 && wreq.waddr == addr) begin
            return wreq.wrdata;
        end
        return shadow[addr];
    endfunction

    function automatic id_pkg::pipe_id_t ref_decode(input id_pkg::pipe_if_t pif,
                                                    input id_pkg::regs_wreq_t wreq,
                                                    input logic ds);
        id_pkg::pipe_id_t      e;
        id_pkg::decoder_resp_t d;
        logic [5:0]            op;
        id_pkg::uint32_t       sext;
        op   = pif.inst[31:26];
        sext = {{16{pif.inst[15]}}, pif.inst[15:0]};
        d        = '0;
        d.rs1    = pif.inst[25:21];
        d.rs2    = pif.inst[20:16];
        d.alu_op = id_pkg::NOP;
        if (op == 6'h00) begin
            case (pif.inst[5:0])
                6'h21: d.alu_op = id_pkg::ADD;
                6'h23: d.alu_op = id_pkg::SUB;
                6'h24: d.alu_op = id_pkg::AND;
                6'h25: d.alu_op = id_pkg::OR;
                6'h26: d.alu_op = id_pkg::XOR;
                6'h2a: d.alu_op = id_pkg::SLT;
                default: d.alu_op = id_pkg::NOP;
            endcase
            d.reg_we = (d.alu_op != id_pkg::NOP);
            d.rd     = d.reg_we ? pif.inst[15:11] : 5'd0;
        end
        // I-type writes go to rt
        if (op == 6'h09 || op == 6'h0d || op == 6'h0f || op == 6'h23) begin
            d.rd      = pif.inst[20:16];
            d.reg_we  = 1'b1;
            d.use_imm = 1'b1;
        end
        case (op)
            6'h09: begin
                d.imm    = sext;
                d.alu_op = id_pkg::ADD;
            end
            6'h0d: begin
                d.imm    = {16'h0, pif.inst[15:0]};
                d.alu_op = id_pkg::OR;
            end
            6'h0f: begin
                d.imm    = {pif.inst[15:0], 16'h0};
                d.alu_op = id_pkg::LUI;
            end
            6'h23: begin
                d.imm     = sext;
                d.alu_op  = id_pkg::ADD;
                d.is_load = 1'b1;
                d.be      = 4'hf;
            end
            6'h2b: begin
                d.imm      = sext;
                d.alu_op   = id_pkg::ADD;
                d.is_store = 1'b1;
                d.be       = 4'hf;
                d.use_imm  = 1'b1;
            end
            6'h04, 6'h05: begin
                d.imm       = sext;
                d.alu_op    = id_pkg::SUB;
                d.is_branch = 1'b1;
            end
            6'h02, 6'h03: begin
                d.imm     = {6'h00, pif.inst[25:0]};
                d.is_jump = 1'b1;
                d.rd      = (op == 6'h03) ? 5'd31 : 5'd0;
                d.reg_we  = (op == 6'h03);
            end
            default: ;
        endcase
        e                   = '0;
        e.valid             = pif.valid;
        e.vaddr             = pif.vaddr;
        e.regs_rddata0      = read_operand(d.rs1, wreq);
        e.regs_rddata1      = read_operand(d.rs2, wreq);
        e.decode_resp       = d;
        e.delayslot         = ds;
        e.dcache_req.vaddr  = e.regs_rddata0 + sext;
        e.dcache_req.wrdata = e.regs_rddata1;
        e.dcache_req.be     = d.be;
        e.dcache_req.read   = d.is_load;
        e.dcache_req.write  = d.is_store;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s exp %h got %h", name, exp, got);
        end
    endtask

    // one cycle of stimulus on the falling edge, plus the model update for the next edge
    task automatic drive_cycle(input logic rst_v, input logic ready_v, input logic flush_v,
                               input logic valid_v, input id_pkg::uint32_t inst_v,
                               input id_pkg::regs_wreq_t wreq_v);
        id_pkg::pipe_if_t pif;
        id_pkg::pipe_id_t nxt;
        @(negedge clk);
        pif.valid = valid_v;
        pif.vaddr = pc;
        pif.inst  = inst_v;
        rst                 = rst_v;
        ready_i             = ready_v;
        pipe_if_flush_i     = flush_v;
        pipe_if_i           = pif;
        pipe_ex_i.regs_wreq = wreq_v;
        nxt = ref_decode(pif, wreq_v, ds_model);
        exp_next      = nxt;
        next_check_en = !rst_v;
        if (rst_v || flush_v) begin
            exp_hold = '0;
        end else if (ready_v) begin
            exp_hold = nxt;
        end
        exp_q.push_back(exp_hold);
        if (rst_v) begin
            for (int i = 0; i < `ID_N_REG; i++) begin
                shadow[i] = '0;
            end
            ds_model = 1'b0;
        end else begin
            if (wreq_v.we && wreq_v.waddr != 5'd0) begin
                shadow[wreq_v.waddr] = wreq_v.wrdata;
            end
            if (flush_v) begin
                ds_model = 1'b0;
            end else if (ready_v && valid_v) begin
                ds_model = nxt.decode_resp.is_branch | nxt.decode_resp.is_jump;
            end
        end
        pc = pc + 32'd4;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        #2;
        $display("test %-8s %s (%0d errors)", name,
                 (n_errors == err_base) ? "ok" : "mismatch", n_errors - err_base);
        err_base = n_errors;
    endtask

    // compare process, one entry per clock edge
    initial begin
        id_pkg::pipe_id_t e;
        forever begin
            @(posedge clk);
            #1;
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_value("pipe_id_o.valid", e.valid, pipe_id_o.valid);
                check_value("pipe_id_o.vaddr", e.vaddr, pipe_id_o.vaddr);
                check_value("pipe_id_o.regs_rddata0", e.regs_rddata0, pipe_id_o.regs_rddata0);
                check_value("pipe_id_o.regs_rddata1", e.regs_rddata1, pipe_id_o.regs_rddata1);
                check_value("pipe_id_o.decode_resp", e.decode_resp, pipe_id_o.decode_resp);
                check_value("pipe_id_o.delayslot", e.delayslot, pipe_id_o.delayslot);
                check_value("pipe_id_o.dcache_req", e.dcache_req, pipe_id_o.dcache_req);
                check_value("ready_o", ready_i, ready_o);
            end
        end
    end

    // combinational next value, once the falling-edge inputs have settled
    initial begin
        forever begin
            @(negedge clk);
            #1;
            if (next_check_en) begin
                check_value("pipe_id_n_o", exp_next, pipe_id_n_o);
            end
        end
    end

    initial begin
        #((TOTAL + MARGIN) * 10);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [4:0]         a;
        logic [4:0]         b;
        id_pkg::regs_wreq_t no_wr;
        void'($urandom(32'hec007af5));
        clk = 1'b0;
        rst = 1'b1;
        ready_i = 1'b0;
        pipe_if_flush_i = 1'b0;
        pipe_if_i = '0;
        pipe_ex_i = '0;
        pc = 32'h0000_1000;
        ds_model = 1'b0;
        exp_hold = '0;
        exp_next = '0;
        next_check_en = 1'b0;
        n_checks = 0;
        n_errors = 0;
        err_base = 0;
        no_wr = '0;
        // first edge is in reset as well
        exp_q.push_back('0);
        repeat (N_RESET - 1) begin
            drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, rand_inst(0), wreq_of(1'b1, 5'd3, $urandom));
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, rand_inst(1), no_wr);
        end_test("reset");

        repeat (N_DECODE) begin
            drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, rand_inst($urandom_range(0, 5)), no_wr);
        end
        end_test("decode");

        // low registers only, so reads hit earlier writes; register zero included
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h21, 5'd0, 5'd1, 5'd2),
                    wreq_of(1'b1, 5'd0, 32'hdead_beef));
        repeat (N_REGFILE - 1) begin
            a = $urandom_range(0, 7);
            b = $urandom_range(0, 7);
            drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h21, a, b, 5'd9),
                        wreq_of($urandom_range(0, 1), $urandom_range(0, 7), $urandom));
        end
        end_test("regfile");

        repeat (N_FORWARD) begin
            a = $urandom_range(1, 31);
            b = $urandom_range(1, 31);
            drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h23, a, b, 5'd10),
                        wreq_of(1'b1, ($urandom_range(0, 1) != 0) ? a : b, $urandom));
        end
        end_test("forward");

        repeat (N_MEM) begin
            a = $urandom_range(1, 7);
            b = $urandom_range(0, 7);
            drive_cycle(1'b0, 1'b1, 1'b0, 1'b1,
                        i_inst(($urandom_range(0, 1) != 0) ? 6'h23 : 6'h2b, a, b, $urandom),
                        wreq_of($urandom_range(0, 1), $urandom_range(1, 7), $urandom));
        end
        end_test("memory");

        // branch, bubbles, slot, jump with stall, flush during stall cancelling a pending slot
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, i_inst(6'h04, 5'd1, 5'd2, 16'h0010), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, rand_inst(0), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, rand_inst(0), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h21, 5'd1, 5'd2, 5'd3), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, {6'h02, 26'h0000400}, no_wr);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, rand_inst(0), no_wr);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, rand_inst(2), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h25, 5'd4, 5'd5, 5'd6), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, i_inst(6'h05, 5'd3, 5'd4, 16'hfff0), no_wr);
        drive_cycle(1'b0, 1'b0, 1'b1, 1'b1, r_inst(6'h21, 5'd1, 5'd1, 5'd7), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, r_inst(6'h26, 5'd2, 5'd3, 5'd8), no_wr);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, {6'h03, 26'h0000800}, no_wr);
        repeat (N_CTRL - 12) begin
            drive_cycle(1'b0, $urandom_range(0, 3) != 0, $urandom_range(0, 9) == 0,
                        $urandom_range(0, 3) != 0, rand_inst($urandom_range(0, 11)),
                        wreq_of($urandom_range(0, 1), $urandom_range(0, 31), $urandom));
        end
        end_test("control");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
